//--- cpu_pkg.sv
// CPU package with shared widths, the ALU opcode enum and the stage buses.
package cpu_pkg;

  localparam int XLEN    = 32;  // Data and PC width.
  localparam int INST_WD = 32;  // Instruction width.
  localparam int REG_AW  = 5;   // Register index width.

  // **************************************************
  // RV32I major opcodes
  // **************************************************
  localparam logic [6:0] OPC_OP     = 7'b0110011;  // Register-register ALU.
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;  // Register-immediate ALU.
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;  // Conditional branches.

  typedef enum logic [3:0] {
    ALU_ADD,     // Add both operands.
    ALU_SUB,     // Subtract second from first.
    ALU_AND,     // Bitwise and of operands.
    ALU_OR,      // Bitwise or of operands.
    ALU_XOR,     // Bitwise xor of operands.
    ALU_PASS_B,  // Pass second operand through.
    ALU_BEQ,     // Branch if operands equal.
    ALU_BNE,     // Branch if operands differ.
    ALU_NOP      // No result, no write.
  } alu_op_e;

  // **************************************************
  // Stage buses
  // **************************************************
  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic            taken;   // Only high for a valid taken branch in ID.
    logic [XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    alu_op_e           op;
    logic [REG_AW-1:0] rd;
    logic              wen;   // Never set for rd of zero.
    logic [XLEN-1:0]   src1;
    logic [XLEN-1:0]   src2;  // Immediate already selected.
    logic [XLEN-1:0]   pc;
  } ds_to_es_t;

  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic              wen;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   pc;
  } es_to_ws_t;

  // Forwarding source seen by decode.
  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   value;
  } byp_t;

endpackage

//--- if_stage.sv
// IF stage: holds the PC, reads the instruction SRAM and passes the word to ID.
`timescale 1ns/1ps

module if_stage #(
  parameter logic [cpu_pkg::XLEN-1:0] PC_RESETVAL = 32'h8000_0000
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  // Branch bus from ID
  input  cpu_pkg::br_bus_t            i_br_bus,
  // To ID
  output logic                        o_fs_to_ds_valid,
  output cpu_pkg::fs_to_ds_t          o_fs_to_ds_bus,
  // Instruction SRAM
  output logic                        o_inst_sram_ren,
  output logic [cpu_pkg::XLEN-1:0]    o_inst_sram_addr,
  input  logic [cpu_pkg::INST_WD-1:0] i_inst_sram_rdata
);

  import cpu_pkg::*;

  logic            fs_valid;
  logic [XLEN-1:0] fs_pc;
  logic [XLEN-1:0] next_pc;

  assign o_fs_to_ds_valid = fs_valid;

  assign next_pc = i_br_bus.taken ? i_br_bus.target : fs_pc + XLEN'(4);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      fs_valid <= 1'b0;
      fs_pc    <= PC_RESETVAL;
    end else begin
      fs_valid <= 1'b1;  // Up from the first cycle after reset.
      if (fs_valid) begin
        fs_pc <= next_pc;
      end
    end
  end

  // SRAM answers in the same cycle.
  assign o_inst_sram_ren     = fs_valid;
  assign o_inst_sram_addr    = fs_pc;
  assign o_fs_to_ds_bus.inst = i_inst_sram_rdata;
  assign o_fs_to_ds_bus.pc   = fs_pc;

  // Branch targets from ID must keep the fetch word-aligned.
  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    fs_valid |-> fs_pc[1:0] == 2'b00);

endmodule

//--- regfile.sv
// Register file: 32 x 32, two combinational read ports, one write port.
`timescale 1ns/1ps

module regfile (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  input  logic [cpu_pkg::REG_AW-1:0] i_raddr1,
  input  logic [cpu_pkg::REG_AW-1:0] i_raddr2,
  output logic [cpu_pkg::XLEN-1:0]   o_rdata1,
  output logic [cpu_pkg::XLEN-1:0]   o_rdata2,
  input  logic                       i_we,
  input  logic [cpu_pkg::REG_AW-1:0] i_waddr,
  input  logic [cpu_pkg::XLEN-1:0]   i_wdata
);

  import cpu_pkg::*;

  logic [XLEN-1:0] regs [1:31];  // x0 has no storage.

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // No write-through here; decode forwards same-cycle writes.
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- id_stage.sv
// ID stage: decodes, reads and forwards operands, and resolves branches.
`timescale 1ns/1ps

module id_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // From IF
  input  logic                       i_fs_to_ds_valid,
  input  cpu_pkg::fs_to_ds_t         i_fs_to_ds_bus,
  // Branch bus to IF
  output cpu_pkg::br_bus_t           o_br_bus,
  // To EX
  output logic                       o_ds_to_es_valid,
  output cpu_pkg::ds_to_es_t         o_ds_to_es_bus,
  // Register file read
  output logic [cpu_pkg::REG_AW-1:0] o_rf_raddr1,
  output logic [cpu_pkg::REG_AW-1:0] o_rf_raddr2,
  input  logic [cpu_pkg::XLEN-1:0]   i_rf_rdata1,
  input  logic [cpu_pkg::XLEN-1:0]   i_rf_rdata2,
  // Forwarding sources
  input  cpu_pkg::byp_t              i_es_byp,
  input  cpu_pkg::byp_t              i_ws_byp
);

  import cpu_pkg::*;

  logic              ds_valid;
  fs_to_ds_t         fs_to_ds_r;

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [REG_AW-1:0] rd;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   imm_u;
  logic [XLEN-1:0]   imm_b;

  alu_op_e           op;
  logic              writes_rd;
  logic [XLEN-1:0]   rs1_val;
  logic [XLEN-1:0]   rs2_val;
  logic [XLEN-1:0]   src2;
  logic              br_eq;
  logic              br_taken;

  // EX result wins over the writeback register.
  function automatic logic [XLEN-1:0] fwd_sel(
    input logic [REG_AW-1:0] addr,
    input logic [XLEN-1:0]   rf_val,
    input byp_t              es,
    input byp_t              ws
  );
    if (es.valid && (es.rd == addr)) begin
      return es.value;
    end
    if (ws.valid && (ws.rd == addr)) begin
      return ws.value;
    end
    return rf_val;
  endfunction

  // **************************************************
  // Input register
  // **************************************************
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else begin
      ds_valid <= i_fs_to_ds_valid && !br_taken;  // Squash the wrong-path fetch.
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid) begin
      fs_to_ds_r <= i_fs_to_ds_bus;
    end
  end

  // **************************************************
  // Decode
  // **************************************************
  assign opcode = fs_to_ds_r.inst[6:0];
  assign funct3 = fs_to_ds_r.inst[14:12];
  assign funct7 = fs_to_ds_r.inst[31:25];
  assign rs1    = fs_to_ds_r.inst[19:15];
  assign rs2    = fs_to_ds_r.inst[24:20];
  assign rd     = fs_to_ds_r.inst[11:7];

  assign imm_i = {{20{fs_to_ds_r.inst[31]}}, fs_to_ds_r.inst[31:20]};
  assign imm_u = {fs_to_ds_r.inst[31:12], 12'b0};
  assign imm_b = {{20{fs_to_ds_r.inst[31]}}, fs_to_ds_r.inst[7],
                  fs_to_ds_r.inst[30:25], fs_to_ds_r.inst[11:8], 1'b0};

  always_comb begin
    op   = ALU_NOP;
    src2 = rs2_val;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = ALU_ADD;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_NOP;
          endcase
        end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
          op = ALU_SUB;
        end
      end
      OPC_OPIMM: begin
        src2 = imm_i;
        if (funct3 == 3'b000) begin
          op = ALU_ADD;  // ADDI.
        end
      end
      OPC_LUI: begin
        op   = ALU_PASS_B;
        src2 = imm_u;
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b000) begin
          op = ALU_BEQ;
        end else if (funct3 == 3'b001) begin
          op = ALU_BNE;
        end
      end
      default: op = ALU_NOP;
    endcase
  end

  assign writes_rd = op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_B};

  // **************************************************
  // Operands and branch
  // **************************************************
  assign o_rf_raddr1 = rs1;
  assign o_rf_raddr2 = rs2;

  assign rs1_val = fwd_sel(rs1, i_rf_rdata1, i_es_byp, i_ws_byp);
  assign rs2_val = fwd_sel(rs2, i_rf_rdata2, i_es_byp, i_ws_byp);

  assign br_eq    = (rs1_val == rs2_val);
  assign br_taken = ds_valid && (((op == ALU_BEQ) && br_eq) || ((op == ALU_BNE) && !br_eq));

  assign o_br_bus.taken  = br_taken;
  assign o_br_bus.target = fs_to_ds_r.pc + imm_b;

  assign o_ds_to_es_valid    = ds_valid;
  assign o_ds_to_es_bus.op   = op;
  assign o_ds_to_es_bus.rd   = rd;
  assign o_ds_to_es_bus.wen  = writes_rd && (rd != '0);  // x0 writes commit unwritten.
  assign o_ds_to_es_bus.src1 = rs1_val;
  assign o_ds_to_es_bus.src2 = src2;
  assign o_ds_to_es_bus.pc   = fs_to_ds_r.pc;

endmodule

//--- ex_stage.sv
// EX stage: ALU, writeback register, register file write and commit port.
`timescale 1ns/1ps

module ex_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // From ID
  input  logic                       i_ds_to_es_valid,
  input  cpu_pkg::ds_to_es_t         i_ds_to_es_bus,
  // Forwarding to ID
  output cpu_pkg::byp_t              o_es_byp,
  output cpu_pkg::byp_t              o_ws_byp,
  // Register file write
  output logic                       o_rf_we,
  output logic [cpu_pkg::REG_AW-1:0] o_rf_waddr,
  output logic [cpu_pkg::XLEN-1:0]   o_rf_wdata,
  // Commit trace
  output logic                       o_commit_valid,
  output logic [cpu_pkg::XLEN-1:0]   o_commit_pc,
  output logic [cpu_pkg::REG_AW-1:0] o_commit_rd,
  output logic                       o_commit_wen,
  output logic [cpu_pkg::XLEN-1:0]   o_commit_data
);

  import cpu_pkg::*;

  logic            es_valid;
  ds_to_es_t       es_r;
  logic [XLEN-1:0] alu_res;
  logic            ws_valid;
  es_to_ws_t       ws_r;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      es_valid <= 1'b0;
      ws_valid <= 1'b0;
    end else begin
      es_valid <= i_ds_to_es_valid;
      ws_valid <= es_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ds_to_es_valid) begin
      es_r <= i_ds_to_es_bus;
    end
  end

  always_comb begin
    case (es_r.op)
      ALU_ADD:    alu_res = es_r.src1 + es_r.src2;
      ALU_SUB:    alu_res = es_r.src1 - es_r.src2;
      ALU_AND:    alu_res = es_r.src1 & es_r.src2;
      ALU_OR:     alu_res = es_r.src1 | es_r.src2;
      ALU_XOR:    alu_res = es_r.src1 ^ es_r.src2;
      ALU_PASS_B: alu_res = es_r.src2;
      default:    alu_res = '0;  // Branches and no-ops.
    endcase
  end

  // Writeback register
  always_ff @(posedge i_clk) begin
    if (es_valid) begin
      ws_r <= '{rd: es_r.rd, wen: es_r.wen, result: alu_res, pc: es_r.pc};
    end
  end

  assign o_es_byp = '{valid: es_valid && es_r.wen, rd: es_r.rd, value: alu_res};
  assign o_ws_byp = '{valid: ws_valid && ws_r.wen, rd: ws_r.rd, value: ws_r.result};

  assign o_rf_we    = ws_valid && ws_r.wen;
  assign o_rf_waddr = ws_r.rd;
  assign o_rf_wdata = ws_r.result;

  assign o_commit_valid = ws_valid;
  assign o_commit_pc    = ws_r.pc;
  assign o_commit_rd    = ws_r.rd;
  assign o_commit_wen   = o_rf_we;
  assign o_commit_data  = ws_r.result;

  // Decode must never let a write to x0 through.
  a_rf_we_commit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_rf_we |-> (o_commit_rd != '0));

endmodule

//--- cpu_top.sv
// CPU top: three-stage pipeline wired to the register file and the SRAM port.
`timescale 1ns/1ps

module cpu_top #(
  parameter logic [cpu_pkg::XLEN-1:0] PC_RESETVAL = 32'h8000_0000
) (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  // Instruction SRAM
  output logic                        o_inst_sram_ren,
  output logic [cpu_pkg::XLEN-1:0]    o_inst_sram_addr,
  input  logic [cpu_pkg::INST_WD-1:0] i_inst_sram_rdata,
  // Commit trace
  output logic                        o_commit_valid,
  output logic [cpu_pkg::XLEN-1:0]    o_commit_pc,
  output logic [cpu_pkg::REG_AW-1:0]  o_commit_rd,
  output logic                        o_commit_wen,
  output logic [cpu_pkg::XLEN-1:0]    o_commit_data
);

  import cpu_pkg::*;

  logic              fs_to_ds_valid;
  fs_to_ds_t         fs_to_ds_bus;
  br_bus_t           br_bus;
  logic              ds_to_es_valid;
  ds_to_es_t         ds_to_es_bus;
  byp_t              es_byp;
  byp_t              ws_byp;
  logic [REG_AW-1:0] rf_raddr1;
  logic [REG_AW-1:0] rf_raddr2;
  logic [XLEN-1:0]   rf_rdata1;
  logic [XLEN-1:0]   rf_rdata2;
  logic              rf_we;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;

  if_stage #(
    .PC_RESETVAL       (PC_RESETVAL)
  ) u_if (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_br_bus          (br_bus),
    .o_fs_to_ds_valid  (fs_to_ds_valid),
    .o_fs_to_ds_bus    (fs_to_ds_bus),
    .o_inst_sram_ren   (o_inst_sram_ren),
    .o_inst_sram_addr  (o_inst_sram_addr),
    .i_inst_sram_rdata (i_inst_sram_rdata)
  );

  id_stage u_id (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_fs_to_ds_valid  (fs_to_ds_valid),
    .i_fs_to_ds_bus    (fs_to_ds_bus),
    .o_br_bus          (br_bus),
    .o_ds_to_es_valid  (ds_to_es_valid),
    .o_ds_to_es_bus    (ds_to_es_bus),
    .o_rf_raddr1       (rf_raddr1),
    .o_rf_raddr2       (rf_raddr2),
    .i_rf_rdata1       (rf_rdata1),
    .i_rf_rdata2       (rf_rdata2),
    .i_es_byp          (es_byp),
    .i_ws_byp          (ws_byp)
  );

  ex_stage u_ex (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_ds_to_es_valid  (ds_to_es_valid),
    .i_ds_to_es_bus    (ds_to_es_bus),
    .o_es_byp          (es_byp),
    .o_ws_byp          (ws_byp),
    .o_rf_we           (rf_we),
    .o_rf_waddr        (rf_waddr),
    .o_rf_wdata        (rf_wdata),
    .o_commit_valid    (o_commit_valid),
    .o_commit_pc       (o_commit_pc),
    .o_commit_rd       (o_commit_rd),
    .o_commit_wen      (o_commit_wen),
    .o_commit_data     (o_commit_data)
  );

  regfile u_rf (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_raddr1          (rf_raddr1),
    .i_raddr2          (rf_raddr2),
    .o_rdata1          (rf_rdata1),
    .o_rdata2          (rf_rdata2),
    .i_we              (rf_we),
    .i_waddr           (rf_waddr),
    .i_wdata           (rf_wdata)
  );

endmodule

//--- tb_cpu.sv
// CPU testbench: directed programs checked against an in-order ISA reference model.
`timescale 1ns/1ps

module tb_cpu;

  localparam logic [31:0] PC_RESETVAL     = 32'h8000_0000;
  localparam int          IMEM_AW         = 7;
  localparam int          IMEM_WORDS      = 1 << IMEM_AW;
  localparam logic [31:0] NOP             = 32'h0000_0013;  // ADDI x0, x0, 0.
  localparam int          RESET_CYCLES    = 8;
  localparam int          FETCH_WAIT      = 4;
  localparam int          COMMIT_WAIT     = 8;
  localparam int          MODEL_STEPS     = 200;
  localparam int          N_TESTS         = 6;
  localparam int          MAX_INSTS       = 160;  // Commits over all tests, with headroom.
  localparam int          WATCHDOG_CYCLES = MAX_INSTS * 4 + N_TESTS * (RESET_CYCLES + 2) + 200;

  localparam logic [6:0] OP_REG = 7'h33;
  localparam logic [6:0] OP_IMM = 7'h13;
  localparam logic [6:0] OP_LUI = 7'h37;
  localparam logic [6:0] OP_BR  = 7'h63;
  localparam logic [6:0] F7_STD = 7'h00;
  localparam logic [6:0] F7_SUB = 7'h20;
  localparam logic [2:0] F3_ADD = 3'd0;
  localparam logic [2:0] F3_XOR = 3'd4;
  localparam logic [2:0] F3_OR  = 3'd6;
  localparam logic [2:0] F3_AND = 3'd7;
  localparam logic [2:0] F3_BEQ = 3'd0;
  localparam logic [2:0] F3_BNE = 3'd1;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic        wen;
    logic        has_data;  // Only register-writing ops carry rd and data.
    logic [31:0] data;
  } commit_t;

  logic        clk;
  logic        rst_n;
  logic        inst_sram_ren;
  logic [31:0] inst_sram_addr;
  logic [31:0] inst_sram_rdata;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic [4:0]  commit_rd;
  logic        commit_wen;
  logic [31:0] commit_data;

  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] word_off;
  int          prog_len;
  commit_t     exp_q [$];
  logic [31:0] rng_state;
  int          cyc = 0;
  int          taken_cnt;
  int          bubbles;
  int          release_cyc;
  int          fetch_cyc;
  int          first_commit_cyc;

  cpu_top #(
    .PC_RESETVAL       (PC_RESETVAL)
  ) u_dut (
    .i_clk             (clk),
    .i_rst_n           (rst_n),
    .o_inst_sram_ren   (inst_sram_ren),
    .o_inst_sram_addr  (inst_sram_addr),
    .i_inst_sram_rdata (inst_sram_rdata),
    .o_commit_valid    (commit_valid),
    .o_commit_pc       (commit_pc),
    .o_commit_rd       (commit_rd),
    .o_commit_wen      (commit_wen),
    .o_commit_data     (commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Instruction memory answers in the same cycle.
  assign word_off        = (inst_sram_addr - PC_RESETVAL) >> 2;
  assign inst_sram_rdata = (word_off < IMEM_WORDS) ? imem[word_off[IMEM_AW-1:0]] : NOP;

  // **************************************************
  // Helpers
  // **************************************************
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] enc_addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], F3_ADD, rd[4:0], OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] enc_br(input logic [2:0] f3, input int rs1, input int rs2,
                                         input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BR};
  endfunction

  task automatic clear_program();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP;
    end
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  // **************************************************
  // Reference ISA model
  // **************************************************
  task automatic model_run();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] idx;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] next_pc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic        writes;
    commit_t     exp_item;
    int          steps;
    int          i;
    exp_q.delete();
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    taken_cnt = 0;
    steps     = 0;
    pc        = PC_RESETVAL;
    idx       = '0;
    while (idx < prog_len && steps < MODEL_STEPS) begin
      inst    = imem[idx[IMEM_AW-1:0]];
      f7      = inst[31:25];
      f3      = inst[14:12];
      rd      = inst[11:7];
      a       = regs[inst[19:15]];
      b       = regs[inst[24:20]];
      writes  = 1'b0;
      res     = '0;
      next_pc = pc + 4;
      case (inst[6:0])
        OP_REG: begin
          writes = 1'b1;
          if (f7 == F7_STD && f3 == F3_ADD) res = a + b;
          else if (f7 == F7_SUB && f3 == F3_ADD) res = a - b;
          else if (f7 == F7_STD && f3 == F3_XOR) res = a ^ b;
          else if (f7 == F7_STD && f3 == F3_OR) res = a | b;
          else if (f7 == F7_STD && f3 == F3_AND) res = a & b;
          else writes = 1'b0;
        end
        OP_IMM: begin
          if (f3 == F3_ADD) begin
            writes = 1'b1;
            res    = a + {{20{inst[31]}}, inst[31:20]};
          end
        end
        OP_LUI: begin
          writes = 1'b1;
          res    = {inst[31:12], 12'h000};
        end
        OP_BR: begin
          if ((f3 == F3_BEQ && a == b) || (f3 == F3_BNE && a != b)) begin
            next_pc = pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            taken_cnt++;
          end
        end
        default: ;  // Unknown encodings retire as no-ops.
      endcase
      exp_item.pc       = pc;
      exp_item.rd       = rd;
      exp_item.wen      = writes && (rd != 0);
      exp_item.has_data = writes;
      exp_item.data     = res;
      exp_q.push_back(exp_item);
      if (writes && rd != 0) begin
        regs[rd] = res;
      end
      pc    = next_pc;
      idx   = (pc - PC_RESETVAL) >> 2;
      steps++;
    end
  endtask

  // **************************************************
  // Run a loaded program
  // **************************************************
  task automatic apply_reset();
    int i;
    @(posedge clk);
    #1 rst_n = 1'b0;
    for (i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk);
      if (i < RESET_CYCLES - 1) begin
        @(negedge clk);
        expect_eq("o_inst_sram_ren", 32'(inst_sram_ren), 32'h0);
        expect_eq("o_commit_valid", 32'(commit_valid), 32'h0);
      end
    end
    #1 rst_n = 1'b1;
    release_cyc = cyc;
  endtask

  task automatic collect_commits();
    commit_t exp;
    int      idle;
    int      got;
    got     = 0;
    idle    = 0;
    bubbles = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      if (commit_valid) begin
        if (got == 0) first_commit_cyc = cyc;
        idle = 0;
        exp  = exp_q.pop_front();
        expect_eq("o_commit_pc", commit_pc, exp.pc);
        expect_eq("o_commit_wen", 32'(commit_wen), 32'(exp.wen));
        if (exp.has_data) begin
          expect_eq("o_commit_rd", 32'(commit_rd), 32'(exp.rd));
          expect_eq("o_commit_data", commit_data, exp.data);
        end
        got++;
      end else begin
        if (got > 0) bubbles++;
        idle++;
        if (idle > COMMIT_WAIT) begin
          abort_run($sformatf("No commit seen for %0d cycles after commit %0d", idle, got));
        end
      end
    end
  endtask

  task automatic run_program();
    int waited;
    model_run();
    apply_reset();
    waited = 0;
    while (!inst_sram_ren) begin
      @(negedge clk);
      waited++;
      if (waited > FETCH_WAIT) abort_run("Instruction read enable never rose after reset");
    end
    fetch_cyc = cyc;
    expect_eq("o_inst_sram_addr", inst_sram_addr, PC_RESETVAL);
    collect_commits();
  endtask

  // **************************************************
  // Directed tests
  // **************************************************
  task automatic test_reset();
    $display("Test: reset and first fetch");
    clear_program();
    emit(enc_addi(1, 0, 5));
    emit(enc_addi(2, 1, 3));
    run_program();
    expect_eq("first fetch delay", fetch_cyc - release_cyc, 1);
    expect_eq("fetch to commit latency", first_commit_cyc - fetch_cyc, 3);
  endtask

  task automatic test_alu_ops();
    $display("Test: ALU operations");
    clear_program();
    emit(enc_addi(1, 0, 'h123));
    emit(enc_addi(2, 0, -1));
    emit(enc_lui(3, 'hABCDE));
    emit(enc_r(F7_STD, F3_ADD, 4, 1, 2));
    emit(enc_r(F7_SUB, F3_ADD, 5, 1, 2));
    emit(enc_r(F7_STD, F3_AND, 6, 3, 2));
    emit(enc_r(F7_STD, F3_OR, 7, 1, 3));
    emit(enc_r(F7_STD, F3_XOR, 8, 2, 3));
    emit(enc_addi(9, 3, 'h7ff));
    emit(enc_r(F7_SUB, F3_ADD, 10, 0, 1));
    run_program();
  endtask

  task automatic test_bypass();
    $display("Test: operand bypass");
    clear_program();
    emit(enc_addi(1, 0, 3));
    emit(enc_r(F7_STD, F3_ADD, 2, 1, 1));   // Distance one.
    emit(enc_r(F7_SUB, F3_ADD, 3, 2, 1));   // Distances one and two.
    emit(enc_r(F7_STD, F3_XOR, 4, 3, 2));
    emit(enc_addi(5, 0, 'h55));
    emit(enc_addi(6, 0, 'h66));
    emit(enc_r(F7_STD, F3_ADD, 7, 5, 0));
    emit(enc_addi(8, 0, 'h11));
    emit(enc_addi(9, 0, 'h22));
    emit(enc_addi(10, 0, 'h33));
    emit(enc_r(F7_STD, F3_OR, 11, 8, 10));  // Distances three and one.
    emit(enc_r(F7_STD, F3_AND, 12, 11, 9));
    emit(enc_addi(13, 0, 1));
    emit(enc_addi(13, 0, 2));
    emit(enc_r(F7_STD, F3_ADD, 14, 13, 13));  // Newest value of x13 must win.
    run_program();
    expect_eq("commit bubbles", bubbles, 0);
  endtask

  task automatic test_branches();
    $display("Test: branches");
    clear_program();
    emit(enc_addi(1, 0, 3));
    emit(enc_addi(2, 0, 3));
    emit(enc_br(F3_BEQ, 1, 2, 12));   // Taken forward.
    emit(enc_addi(3, 0, 3));
    emit(enc_addi(3, 0, 4));
    emit(enc_br(F3_BNE, 1, 2, 8));    // Not taken.
    emit(enc_addi(4, 0, 1));
    emit(enc_br(F3_BEQ, 4, 0, 8));    // Not taken, operand one back.
    emit(enc_addi(5, 0, 2));
    emit(enc_addi(5, 5, -1));
    emit(enc_addi(6, 6, 5));
    emit(enc_br(F3_BNE, 5, 0, -8));   // Backward loop.
    emit(enc_r(F7_STD, F3_ADD, 7, 6, 1));
    emit(enc_br(F3_BEQ, 0, 0, 8));
    emit(enc_addi(8, 0, 'h7ff));
    emit(enc_addi(9, 0, 9));
    run_program();
    expect_eq("commit bubbles", bubbles, taken_cnt);
  endtask

  task automatic test_reg_zero();
    $display("Test: register zero");
    clear_program();
    emit(enc_addi(0, 0, 'h5a));
    emit(enc_lui(0, 'h12345));
    emit(enc_r(F7_STD, F3_ADD, 1, 0, 0));
    emit(enc_addi(2, 0, 7));
    emit(enc_r(F7_STD, F3_ADD, 0, 2, 2));
    emit(enc_r(F7_STD, F3_ADD, 3, 0, 2));
    run_program();
  endtask

  task automatic test_random();
    logic [31:0] r;
    int          kind;
    int          i;
    $display("Test: random ALU program");
    clear_program();
    for (i = 0; i < 64; i++) begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      kind      = int'(r[31:29]) % 7;
      case (kind)
        0: emit(enc_r(F7_STD, F3_ADD, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
        1: emit(enc_r(F7_SUB, F3_ADD, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
        2: emit(enc_r(F7_STD, F3_AND, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
        3: emit(enc_r(F7_STD, F3_OR, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
        4: emit(enc_r(F7_STD, F3_XOR, int'(r[2:0]), int'(r[5:3]), int'(r[8:6])));
        5: emit(enc_addi(int'(r[2:0]), int'(r[5:3]), int'(r[20:9])));
        default: emit(enc_lui(int'(r[2:0]), int'(r[28:9])));
      endcase
    end
    run_program();
    expect_eq("commit bubbles", bubbles, 0);
  endtask

  initial begin
    rst_n     = 1'b0;
    rng_state = 32'd56;
    clear_program();
    test_reset();
    test_alu_ops();
    test_bypass();
    test_branches();
    test_reg_zero();
    test_random();
    $display("Simulation passed");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

//--- sim.f
cpu_pkg.sv
if_stage.sv
regfile.sv
id_stage.sv
ex_stage.sv
cpu_top.sv
tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# Build the CPU testbench with Verilator, run it and check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f sim.f \
  --Mdir obj_dir -o tb_cpu_sim
if [ $? -ne 0 ]; then
  echo "ERROR: Verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "ERROR: simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Simulation passed" sim.log; then
  echo "PASS"
  exit 0
fi
echo "ERROR: pass message not found in sim.log"
exit 1
